// ==== dv/ttc_chk.sv ====
//--------------------------------------------------------------------------
// Concurrent checks on the timer counter top level ports
// APB read data, penable protocol and interrupt outputs
//--------------------------------------------------------------------------
`include "ttc_config.svh"

module ttc_chk (
   input logic                   pclk,
   input logic                   arst_n,
   input logic                   psel,
   input logic                   penable,
   input logic                   pwrite,
   input logic [`TTC_APB_DW-1:0] prdata,
   input logic [`TTC_NUM_CH-1:0] interrupt
);
   timeunit 1ns;
   timeprecision 1ps;

   int fail_count;   // Count of failed assertions

   // Read data only in a read access
   a_prdata_idle: assert property (@(posedge pclk) disable iff (!arst_n)
      !(psel && penable && !pwrite) |-> prdata == '0)
      else begin
         $error("prdata is not zero outside a read access");
         fail_count++;
      end

   a_irq_in_reset: assert property (@(posedge pclk)
      !arst_n |-> interrupt == '0)
      else begin
         $error("interrupt is high during reset");
         fail_count++;
      end

   // Access phase always inside a selected transfer
   a_penable_psel: assert property (@(posedge pclk) disable iff (!arst_n)
      penable |-> psel)
      else begin
         $error("penable is high without psel");
         fail_count++;
      end

   a_irq_known: assert property (@(posedge pclk) disable iff (!arst_n)
      !$isunknown(interrupt))
      else begin
         $error("interrupt has unknown bits");
         fail_count++;
      end

endmodule

// ==== dv/ttc_clk_gen.sv ====
//--------------------------------------------------------------------------
// Testbench clock and reset
// 40 ns pclk and arst_n low for 16 cycles
//--------------------------------------------------------------------------
module ttc_clk_gen (
   output logic pclk,
   output logic arst_n
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      pclk = 1'b0;
      forever #20 pclk = ~pclk;   // 40 ns period
   end

   // Released on a falling edge away from the DUT's sampling edge
   initial begin
      arst_n = 1'b0;
      repeat (16) @(posedge pclk);
      @(negedge pclk);
      arst_n = 1'b1;
   end

endmodule

// ==== dv/ttc_tb.sv ====
//--------------------------------------------------------------------------
// Directed testbench of the triple timer counter lite
// APB driver tasks, five tests, per-test lines and final result
//--------------------------------------------------------------------------
`include "ttc_config.svh"

module ttc_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int IRQ_TIMEOUT = 2000;   // Cycles per interrupt wait

   logic                   pclk;
   logic                   arst_n;
   logic                   psel;
   logic                   penable;
   logic                   pwrite;
   logic [`TTC_ADDR_W-1:0] paddr;
   logic [`TTC_APB_DW-1:0] pwdata;
   logic [`TTC_APB_DW-1:0] prdata;
   logic [`TTC_NUM_CH-1:0] interrupt;

   int cycle_cnt;      // Rising edges since start
   int read_cycle;     // cycle_cnt at the last read sample
   int test_errors;
   int tests_run;
   int tests_failed;
   int total_errors;

   ttc_clk_gen i_clk_gen (.pclk(pclk), .arst_n(arst_n));

   ttc_lite i_dut (
      .pclk      (pclk),
      .arst_n    (arst_n),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .interrupt (interrupt)
   );

   bind ttc_lite ttc_chk i_chk (.*);

   always @(posedge pclk) cycle_cnt <= cycle_cnt + 1;

   //------------------------------------------------------------------------
   // APB driver and check helpers
   //------------------------------------------------------------------------
   function automatic logic [`TTC_ADDR_W-1:0] reg_addr(input int ch, input int idx);
      return {ch[1:0], idx[3:0], 2'b00};   // Channel, register, byte lane
   endfunction

   // Readable bits of each register
   function automatic logic [31:0] field_mask(input int idx);
      case (idx)
         0:       return 32'h1F;           // exp and enable
         1:       return 32'h0F;           // cnt_reset never reads back
         3, 4, 5, 6: return 32'hFFFF;
         8:       return 32'h0F;
         default: return 32'h0;
      endcase
   endfunction

   task automatic apb_write(input int ch, input int idx, input logic [31:0] data);
      @(negedge pclk);
      psel    = 1'b1;                      // Setup
      pwrite  = 1'b1;
      paddr   = reg_addr(ch, idx);
      pwdata  = data;
      @(negedge pclk);
      penable = 1'b1;                      // Access
      @(negedge pclk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input int ch, input int idx, output logic [31:0] data);
      @(negedge pclk);
      psel    = 1'b1;
      pwrite  = 1'b0;
      paddr   = reg_addr(ch, idx);
      @(negedge pclk);
      penable = 1'b1;
      #10;                                 // Sample mid access before the clearing edge
      data       = prdata;
      read_cycle = cycle_cnt;
      @(negedge pclk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic read_check(input int ch, input int idx, input logic [31:0] exp);
      logic [31:0] got;
      apb_read(ch, idx, got);
      assert (got === exp) else begin
         $display("error at %0t ns: channel %0d register %0d read 0x%0h, expected 0x%0h",
                  $time, ch, idx, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_cond(input logic cond, input string msg);
      assert (cond === 1'b1) else begin
         $display("error at %0t ns: %s", $time, msg);
         test_errors++;
      end
   endtask

   task automatic wait_irq(input int ch);
      int n;
      n = 0;
      while (interrupt[ch-1] !== 1'b1 && n < IRQ_TIMEOUT) begin
         @(negedge pclk);
         n++;
      end
      assert (interrupt[ch-1] === 1'b1) else begin
         $display("timeout: interrupt of channel %0d did not rise within %0d cycles",
                  ch, IRQ_TIMEOUT);
         test_errors++;
      end
   endtask

   // Stop, zero, mask and clear one channel
   task automatic park_channel(input int ch);
      logic [31:0] dummy;
      apb_write(ch, 1, 32'h11);
      apb_write(ch, 8, 32'h0);
      apb_read(ch, 7, dummy);
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (test_errors == 0) begin
         $display("test %s: passed", name);
      end else begin
         $display("test %s: failed with %0d errors", name, test_errors);
         tests_failed++;
      end
      total_errors += test_errors;
      test_errors = 0;
   endtask

   //------------------------------------------------------------------------
   // Tests
   //------------------------------------------------------------------------
   task automatic test_reset_access();
      logic [31:0] wval;
      for (int ch = 1; ch <= `TTC_NUM_CH; ch++) begin
         for (int idx = 0; idx < 16; idx++) begin
            read_check(ch, idx, (idx == 1) ? 32'h1 : 32'h0);   // Only disable set
         end
      end
      read_check(0, 3, 32'h0);             // Channel 0 is empty
      for (int ch = 1; ch <= `TTC_NUM_CH; ch++) begin
         for (int idx = 0; idx <= 8; idx++) begin
            if (idx != 2 && idx != 7) begin
               wval = $urandom;
               apb_write(ch, idx, wval);
               read_check(ch, idx, wval & field_mask(idx));
            end
         end
         apb_write(ch, 1, 32'h11);         // Disable plus cnt_reset
         read_check(ch, 1, 32'h1);
         apb_write(ch, 2, $urandom);       // Count is read only
         read_check(ch, 2, 32'h0);
         park_channel(ch);
      end
      finish_test("reset_and_access");
   endtask

   task automatic test_free_count();
      logic [31:0] c0;
      logic [31:0] c1;
      int          t0;
      int          d;
      int          n;
      apb_write(3, 0, 32'h0);              // Tick every cycle
      apb_write(3, 1, 32'h10);             // Up from zero
      apb_read(3, 2, c0);
      t0 = read_cycle;
      repeat ($urandom_range(30, 5)) @(negedge pclk);
      apb_read(3, 2, c1);
      d = int'(c1 - c0);
      n = read_cycle - t0;
      check_cond(d == n, $sformatf("count moved %0d in %0d cycles", d, n));
      apb_write(3, 0, 32'h5);              // Exponent 2 divides by 8
      apb_read(3, 2, c0);
      t0 = read_cycle;
      repeat ($urandom_range(120, 40)) @(negedge pclk);
      apb_read(3, 2, c1);
      d = int'(c1 - c0);
      n = (read_cycle - t0) / 8;
      check_cond(d >= n - 1 && d <= n + 1,
                 $sformatf("prescaled count moved %0d, expected %0d within one", d, n));
      apb_write(3, 0, 32'h0);
      park_channel(3);
      finish_test("free_count");
   endtask

   task automatic test_interval_wrap();
      apb_write(1, 0, 32'h0);
      apb_write(1, 3, 32'd10);
      apb_write(1, 8, 32'h1);              // Wrap event only
      apb_write(1, 1, 32'h12);             // Interval mode from zero
      wait_irq(1);
      apb_write(1, 1, 32'h3);              // Hold the count
      read_check(1, 7, 32'h1);
      read_check(1, 7, 32'h0);
      check_cond(interrupt[0] == 1'b0, "interrupt of channel 1 still high after clear");
      park_channel(1);
      finish_test("interval_wrap");
   endtask

   task automatic test_down_match();
      logic [31:0] st;
      apb_write(2, 0, 32'h0);
      apb_write(2, 3, 32'd50);
      apb_write(2, 4, 32'd60);             // Never reached below interval
      apb_write(2, 5, 32'd20);
      apb_write(2, 8, 32'h4);              // Match 2 only
      apb_write(2, 1, 32'h1E);             // Down, interval, match_en, zero
      wait_irq(2);
      apb_write(2, 1, 32'h0F);
      apb_read(2, 7, st);
      check_cond(st[2] == 1'b1, $sformatf("status 0x%0h lacks match 2", st));
      check_cond(st[1] == 1'b0, $sformatf("status 0x%0h has match 1", st));
      park_channel(2);
      finish_test("down_match");
   endtask

   task automatic test_independence();
      int sel;
      for (int ch = 1; ch <= `TTC_NUM_CH; ch++) begin
         park_channel(ch);
      end
      sel = $urandom_range(`TTC_NUM_CH, 1);
      for (int ch = 1; ch <= `TTC_NUM_CH; ch++) begin
         if (ch != sel) apb_write(ch, 8, 32'hF);   // Idle but unmasked
      end
      apb_write(sel, 0, 32'h0);
      apb_write(sel, 3, 32'd10);
      apb_write(sel, 8, 32'h1);
      apb_write(sel, 1, 32'h12);
      wait_irq(sel);
      for (int ch = 1; ch <= `TTC_NUM_CH; ch++) begin
         if (ch != sel) begin
            check_cond(interrupt[ch-1] == 1'b0,
                       $sformatf("interrupt of idle channel %0d is high", ch));
            read_check(ch, 7, 32'h0);
         end
      end
      for (int ch = 1; ch <= `TTC_NUM_CH; ch++) begin
         park_channel(ch);
      end
      finish_test("channel_independence");
   endtask

   initial begin
      int n;
      void'($urandom(69));
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      n = 0;
      while (arst_n !== 1'b1 && n < 100) begin
         @(negedge pclk);
         n++;
      end
      assert (arst_n === 1'b1) else begin
         $display("reset was never released");
         total_errors++;
      end
      test_reset_access();
      test_free_count();
      test_interval_wrap();
      test_down_match();
      test_independence();
      total_errors += i_dut.i_chk.fail_count;
      $display("tests run %0d, failed %0d, errors %0d, assertion failures %0d",
               tests_run, tests_failed, total_errors, i_dut.i_chk.fail_count);
      if (total_errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Verilator build and run of the timer counter testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module ttc_tb \
   -f vlog.f -o ttc_sim > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/ttc_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -qx "RESULT: PASS" sim.log && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// ==== src/ttc_apb_regs.sv ====
//--------------------------------------------------------------------------
// APB register decoder for all timer channels
// Write strobes, status read clear and read data mux
//--------------------------------------------------------------------------
`include "ttc_config.svh"

module ttc_apb_regs import ttc_pkg::*; (
   input  logic                                        pclk,
   input  logic                                        arst_n,
   input  logic                                        psel,
   input  logic                                        penable,
   input  logic                                        pwrite,
   input  logic [`TTC_ADDR_W-1:0]                      paddr,
   output logic [`TTC_APB_DW-1:0]                      prdata,
   // Per channel strobes
   output logic [`TTC_NUM_CH-1:0]                      clk_sel,
   output logic [`TTC_NUM_CH-1:0]                      cntr_sel,
   output logic [`TTC_NUM_CH-1:0]                      interval_sel,
   output logic [`TTC_NUM_CH-1:0][2:0]                 match_sel,
   output logic [`TTC_NUM_CH-1:0]                      ien_sel,
   output logic [`TTC_NUM_CH-1:0]                      status_clr,
   // Channel register contents
   input  ttc_clk_ctrl_t  [`TTC_NUM_CH-1:0]            clk_ctrl,
   input  ttc_cntr_ctrl_t [`TTC_NUM_CH-1:0]            cntr_ctrl,
   input  logic [`TTC_NUM_CH-1:0][`TTC_CNT_W-1:0]      count,
   input  logic [`TTC_NUM_CH-1:0][`TTC_CNT_W-1:0]      interval,
   input  logic [`TTC_NUM_CH-1:0][2:0][`TTC_CNT_W-1:0] match,
   input  logic [`TTC_NUM_CH-1:0][`TTC_EVT_W-1:0]      status,
   input  logic [`TTC_NUM_CH-1:0][`TTC_EVT_W-1:0]      ien
);

   localparam int CH_W = `TTC_CH_MSB - `TTC_CH_LSB + 1;

   logic                  acc_done;      // Access cycle already served
   logic                  access;        // First access cycle only
   logic [CH_W-1:0]       ch_field;      // Channel number from address
   logic [CH_W-1:0]       ch_idx;        // Zero based channel
   logic                  ch_valid;
   ttc_reg_e              reg_idx;
   logic                  wr_en;
   logic                  rd_en;
   logic [`TTC_CNT_W-1:0] rd_data;

   // Blocks a second strobe if penable is held
   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         acc_done <= 1'b0;
      end else begin
         acc_done <= psel & penable;
      end
   end

   assign access   = psel & penable & ~acc_done;
   assign ch_field = paddr[`TTC_CH_MSB:`TTC_CH_LSB];
   assign ch_idx   = ch_field - 1'b1;
   assign ch_valid = (ch_field != '0);   // Channel 0 is empty space
   assign reg_idx  = ttc_reg_e'(paddr[`TTC_REG_MSB:`TTC_REG_LSB]);
   assign wr_en    = access & pwrite & ch_valid;
   assign rd_en    = access & ~pwrite & ch_valid;

   //------------------------------------------------------------------------
   // Write and read clear strobes
   //------------------------------------------------------------------------
   always_comb begin
      clk_sel      = '0;
      cntr_sel     = '0;
      interval_sel = '0;
      match_sel    = '0;
      ien_sel      = '0;
      status_clr   = '0;
      for (int i = 0; i < `TTC_NUM_CH; i++) begin
         if (ch_field == CH_W'(i + 1)) begin
            clk_sel[i]      = wr_en & (reg_idx == REG_CLK_CTRL);
            cntr_sel[i]     = wr_en & (reg_idx == REG_CNTR_CTRL);
            interval_sel[i] = wr_en & (reg_idx == REG_INTERVAL);
            match_sel[i][0] = wr_en & (reg_idx == REG_MATCH1);
            match_sel[i][1] = wr_en & (reg_idx == REG_MATCH2);
            match_sel[i][2] = wr_en & (reg_idx == REG_MATCH3);
            ien_sel[i]      = wr_en & (reg_idx == REG_IER);
            status_clr[i]   = rd_en & (reg_idx == REG_ISR);   // Read of status
         end
      end
   end

   //------------------------------------------------------------------------
   // Read data mux
   //------------------------------------------------------------------------
   always_comb begin
      case (reg_idx)
         REG_CLK_CTRL:  rd_data = `TTC_CNT_W'(clk_ctrl[ch_idx]);
         REG_CNTR_CTRL: rd_data = `TTC_CNT_W'(cntr_ctrl[ch_idx]);   // cnt_reset stored as 0
         REG_COUNT:     rd_data = count[ch_idx];
         REG_INTERVAL:  rd_data = interval[ch_idx];
         REG_MATCH1:    rd_data = match[ch_idx][0];
         REG_MATCH2:    rd_data = match[ch_idx][1];
         REG_MATCH3:    rd_data = match[ch_idx][2];
         REG_ISR:       rd_data = `TTC_CNT_W'(status[ch_idx]);
         REG_IER:       rd_data = `TTC_CNT_W'(ien[ch_idx]);
         default:       rd_data = '0;   // Unused index
      endcase
   end

   // Bus is driven only in a read access
   assign prdata = rd_en ? {{(`TTC_APB_DW - `TTC_CNT_W){1'b0}}, rd_data} : '0;

endmodule

// ==== src/ttc_channel.sv ====
//--------------------------------------------------------------------------
// One timer channel with its configuration registers
// Prescaler, counter and interrupt blocks
//--------------------------------------------------------------------------
`include "ttc_config.svh"

module ttc_channel import ttc_pkg::*; (
   input  logic                       pclk,
   input  logic                       arst_n,
   input  logic [`TTC_CNT_W-1:0]      pwdata,
   input  logic                       clk_sel,
   input  logic                       cntr_sel,
   input  logic                       interval_sel,
   input  logic [2:0]                 match_sel,
   input  logic                       ien_sel,
   input  logic                       status_clr,
   output ttc_clk_ctrl_t              clk_ctrl,
   output ttc_cntr_ctrl_t             cntr_ctrl,
   output logic [`TTC_CNT_W-1:0]      count,
   output logic [`TTC_CNT_W-1:0]      interval,
   output logic [2:0][`TTC_CNT_W-1:0] match,
   output logic [`TTC_EVT_W-1:0]      status,
   output logic [`TTC_EVT_W-1:0]      ien,
   output logic                       irq
);

   ttc_cntr_ctrl_t cntr_wdata;   // Write value without the reset bit
   logic           cnt_reset;
   logic           tick;
   logic [`TTC_EVT_W-1:0] evt;

   always_comb begin
      cntr_wdata           = ttc_cntr_ctrl_t'(pwdata[$bits(ttc_cntr_ctrl_t)-1:0]);
      cnt_reset            = cntr_sel & cntr_wdata.cnt_reset;
      cntr_wdata.cnt_reset = 1'b0;   // Never stored
   end

   //------------------------------------------------------------------------
   // Configuration registers
   //------------------------------------------------------------------------
   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         clk_ctrl              <= '0;
         cntr_ctrl             <= '0;
         cntr_ctrl.cnt_disable <= 1'b1;   // Stopped out of reset
         interval              <= '0;
         match                 <= '0;
         ien                   <= '0;
      end else begin
         if (clk_sel)      clk_ctrl  <= ttc_clk_ctrl_t'(pwdata[$bits(ttc_clk_ctrl_t)-1:0]);
         if (cntr_sel)     cntr_ctrl <= cntr_wdata;
         if (interval_sel) interval  <= pwdata;
         for (int m = 0; m < 3; m++) begin
            if (match_sel[m]) match[m] <= pwdata;
         end
         if (ien_sel)      ien       <= pwdata[`TTC_EVT_W-1:0];
      end
   end

   ttc_prescaler i_prescaler (
      .pclk     (pclk),
      .arst_n   (arst_n),
      .clk_ctrl (clk_ctrl),
      .restart  (clk_sel),
      .tick     (tick)
   );

   ttc_counter i_counter (
      .pclk      (pclk),
      .arst_n    (arst_n),
      .tick      (tick),
      .cntr_ctrl (cntr_ctrl),
      .interval  (interval),
      .match     (match),
      .cnt_reset (cnt_reset),
      .count     (count),
      .evt       (evt)
   );

   ttc_irq i_irq (
      .pclk       (pclk),
      .arst_n     (arst_n),
      .evt        (evt),
      .ien        (ien),
      .status_clr (status_clr),
      .status     (status),
      .irq        (irq)
   );

endmodule

// ==== src/ttc_config.svh ====
//--------------------------------------------------------------------------
// Build constants of the triple timer counter lite
// Channel count, data widths and APB address fields
//--------------------------------------------------------------------------
`ifndef TTC_CONFIG_SVH
`define TTC_CONFIG_SVH

`define TTC_NUM_CH  3          // Timer channels
`define TTC_CNT_W   16         // Counter and register data width
`define TTC_PSC_W   4          // Prescale exponent field
`define TTC_EVT_W   4          // Interrupt events per channel
`define TTC_ADDR_W  8          // APB address width
`define TTC_APB_DW  32         // APB data bus width

// Address fields
`define TTC_CH_MSB  7          // Channel number 1 to 3
`define TTC_CH_LSB  6
`define TTC_REG_MSB 5          // Register index within channel
`define TTC_REG_LSB 2

`endif

// ==== src/ttc_counter.sv ====
//--------------------------------------------------------------------------
// Up/down counter of one timer channel
// Interval or overflow wrap and match event detection
//--------------------------------------------------------------------------
`include "ttc_config.svh"

module ttc_counter import ttc_pkg::*; (
   input  logic                      pclk,
   input  logic                      arst_n,
   input  logic                      tick,
   input  ttc_cntr_ctrl_t            cntr_ctrl,
   input  logic [`TTC_CNT_W-1:0]     interval,
   input  logic [2:0][`TTC_CNT_W-1:0] match,
   input  logic                      cnt_reset,
   output logic [`TTC_CNT_W-1:0]     count,
   output logic [`TTC_EVT_W-1:0]     evt        // Valid at the update edge
);

   logic [`TTC_CNT_W-1:0] cnt_nxt;
   logic [`TTC_CNT_W-1:0] wrap_at;
   logic                  wrap;
   logic                  step;                 // Count moves this cycle

   assign step    = tick & ~cntr_ctrl.cnt_disable & ~cnt_reset;
   assign wrap_at = cntr_ctrl.interval_mode ? interval : '1;

   //------------------------------------------------------------------------
   // Next count
   //------------------------------------------------------------------------
   always_comb begin
      wrap = 1'b0;
      if (cntr_ctrl.decrement) begin
         if (count == '0) begin
            cnt_nxt = wrap_at;                  // Reload
            wrap    = 1'b1;
         end else begin
            cnt_nxt = count - 1'b1;
         end
      end else begin
         // Overflow still wraps if interval is below count
         if (count == wrap_at || count == '1) begin
            cnt_nxt = '0;
            wrap    = 1'b1;
         end else begin
            cnt_nxt = count + 1'b1;
         end
      end
   end

   // Events from the new count
   always_comb begin
      evt = '0;
      if (step) begin
         evt[EVT_WRAP]   = wrap;
         evt[EVT_MATCH1] = cntr_ctrl.match_en & (match[0] == cnt_nxt);
         evt[EVT_MATCH2] = cntr_ctrl.match_en & (match[1] == cnt_nxt);
         evt[EVT_MATCH3] = cntr_ctrl.match_en & (match[2] == cnt_nxt);
      end
   end

   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         count <= '0;
      end else if (cnt_reset) begin
         count <= '0;                           // No event
      end else if (step) begin
         count <= cnt_nxt;
      end
   end

endmodule

// ==== src/ttc_irq.sv ====
//--------------------------------------------------------------------------
// Interrupt status of one timer channel
// Sticky event bits with read clear and masked interrupt
//--------------------------------------------------------------------------
`include "ttc_config.svh"

module ttc_irq (
   input  logic                  pclk,
   input  logic                  arst_n,
   input  logic [`TTC_EVT_W-1:0] evt,
   input  logic [`TTC_EVT_W-1:0] ien,
   input  logic                  status_clr,
   output logic [`TTC_EVT_W-1:0] status,
   output logic                  irq
);

   logic [`TTC_EVT_W-1:0] status_kept;   // Status after any clear

   assign status_kept = status_clr ? '0 : status;

   // Events of the clearing cycle survive
   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         status <= '0;
      end else begin
         status <= status_kept | evt;
      end
   end

   // From registers only
   assign irq = |(status & ien);

endmodule

// ==== src/ttc_lite.sv ====
//--------------------------------------------------------------------------
// Top level of the triple timer counter lite
// APB register decoder and three timer channels
//--------------------------------------------------------------------------
`include "ttc_config.svh"

module ttc_lite import ttc_pkg::*; (
   input  logic                   pclk,
   input  logic                   arst_n,
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  logic [`TTC_ADDR_W-1:0] paddr,
   input  logic [`TTC_APB_DW-1:0] pwdata,
   output logic [`TTC_APB_DW-1:0] prdata,
   output logic [`TTC_NUM_CH-1:0] interrupt   // Bit i-1 is channel i
);

   // Strobes to the channels
   logic [`TTC_NUM_CH-1:0]                      clk_sel;
   logic [`TTC_NUM_CH-1:0]                      cntr_sel;
   logic [`TTC_NUM_CH-1:0]                      interval_sel;
   logic [`TTC_NUM_CH-1:0][2:0]                 match_sel;
   logic [`TTC_NUM_CH-1:0]                      ien_sel;
   logic [`TTC_NUM_CH-1:0]                      status_clr;
   // Register contents back to the decoder
   ttc_clk_ctrl_t  [`TTC_NUM_CH-1:0]            clk_ctrl;
   ttc_cntr_ctrl_t [`TTC_NUM_CH-1:0]            cntr_ctrl;
   logic [`TTC_NUM_CH-1:0][`TTC_CNT_W-1:0]      count;
   logic [`TTC_NUM_CH-1:0][`TTC_CNT_W-1:0]      interval;
   logic [`TTC_NUM_CH-1:0][2:0][`TTC_CNT_W-1:0] match;
   logic [`TTC_NUM_CH-1:0][`TTC_EVT_W-1:0]      status;
   logic [`TTC_NUM_CH-1:0][`TTC_EVT_W-1:0]      ien;

   ttc_apb_regs i_apb_regs (
      .pclk         (pclk),
      .arst_n       (arst_n),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .prdata       (prdata),
      .clk_sel      (clk_sel),
      .cntr_sel     (cntr_sel),
      .interval_sel (interval_sel),
      .match_sel    (match_sel),
      .ien_sel      (ien_sel),
      .status_clr   (status_clr),
      .clk_ctrl     (clk_ctrl),
      .cntr_ctrl    (cntr_ctrl),
      .count        (count),
      .interval     (interval),
      .match        (match),
      .status       (status),
      .ien          (ien)
   );

   // One channel per interrupt line
   for (genvar gi = 0; gi < `TTC_NUM_CH; gi++) begin : g_ch
      ttc_channel i_channel (
         .pclk         (pclk),
         .arst_n       (arst_n),
         .pwdata       (pwdata[`TTC_CNT_W-1:0]),
         .clk_sel      (clk_sel[gi]),
         .cntr_sel     (cntr_sel[gi]),
         .interval_sel (interval_sel[gi]),
         .match_sel    (match_sel[gi]),
         .ien_sel      (ien_sel[gi]),
         .status_clr   (status_clr[gi]),
         .clk_ctrl     (clk_ctrl[gi]),
         .cntr_ctrl    (cntr_ctrl[gi]),
         .count        (count[gi]),
         .interval     (interval[gi]),
         .match        (match[gi]),
         .status       (status[gi]),
         .ien          (ien[gi]),
         .irq          (interrupt[gi])
      );
   end

endmodule

// ==== src/ttc_pkg.sv ====
//--------------------------------------------------------------------------
// Shared types of the timer counter
// Register index, clock and counter control fields, event bits
//--------------------------------------------------------------------------
`include "ttc_config.svh"

package ttc_pkg;

   // Register index from paddr[5:2]
   typedef enum logic [3:0] {
      REG_CLK_CTRL  = 4'd0,
      REG_CNTR_CTRL = 4'd1,
      REG_COUNT     = 4'd2,    // Read only
      REG_INTERVAL  = 4'd3,
      REG_MATCH1    = 4'd4,
      REG_MATCH2    = 4'd5,
      REG_MATCH3    = 4'd6,
      REG_ISR       = 4'd7,    // Clears on read
      REG_IER       = 4'd8
   } ttc_reg_e;

   // Clock control with prescale_en in bit 0
   typedef struct packed {
      logic [`TTC_PSC_W-1:0] prescale_exp;   // Tick every 2**(exp+1)
      logic                  prescale_en;
   } ttc_clk_ctrl_t;

   // Counter control with the stop bit in bit 0
   typedef struct packed {
      logic cnt_reset;         // Self clearing
      logic match_en;
      logic decrement;
      logic interval_mode;
      logic cnt_disable;       // Set out of reset
   } ttc_cntr_ctrl_t;

   // Status and enable bit positions
   typedef enum logic [1:0] {
      EVT_WRAP   = 2'd0,       // Interval or overflow
      EVT_MATCH1 = 2'd1,
      EVT_MATCH2 = 2'd2,
      EVT_MATCH3 = 2'd3
   } ttc_evt_e;

endpackage

// ==== src/ttc_prescaler.sv ====
//--------------------------------------------------------------------------
// Clock prescaler of one timer channel
// Counting tick at pclk or pclk divided by 2**(exp+1)
//--------------------------------------------------------------------------
`include "ttc_config.svh"

module ttc_prescaler import ttc_pkg::*; (
   input  logic          pclk,
   input  logic          arst_n,
   input  ttc_clk_ctrl_t clk_ctrl,
   input  logic          restart,     // Clock control written
   output logic          tick
);

   // Wide enough for the largest exponent
   localparam int PW = 1 << `TTC_PSC_W;

   logic [PW-1:0]        psc_cnt;     // Free running
   logic [PW-1:0]        wrap_mask;   // Low exp+1 bits
   logic [`TTC_PSC_W:0]  wrap_bits;

   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         psc_cnt <= '0;
      end else if (restart) begin
         psc_cnt <= '0;               // New divide starts clean
      end else begin
         psc_cnt <= psc_cnt + 1'b1;
      end
   end

   assign wrap_bits = {1'b0, clk_ctrl.prescale_exp} + 1'b1;
   assign wrap_mask = ~({PW{1'b1}} << wrap_bits);

   // Tick on the cycle before the low bits wrap
   always_comb begin
      if (clk_ctrl.prescale_en) begin
         tick = ((psc_cnt & wrap_mask) == wrap_mask);
      end else begin
         tick = 1'b1;                 // Undivided
      end
   end

endmodule

// ==== vlog.f ====
+incdir+src
src/ttc_pkg.sv
src/ttc_apb_regs.sv
src/ttc_prescaler.sv
src/ttc_counter.sv
src/ttc_irq.sv
src/ttc_channel.sv
src/ttc_lite.sv
dv/ttc_clk_gen.sv
dv/ttc_chk.sv
dv/ttc_tb.sv
